// ==== sim.f ====
rtl/gba_io_pkg.sv
rtl/io_regs.sv
rtl/snes_controller.sv
rtl/led_controller.sv
rtl/gba_io_top.sv
sim/io_checker.sv
sim/tb_gba_io_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_gba_io_top -f sim.f -o tb_gba_io_top

out=$(./obj_dir/tb_gba_io_top)
echo "$out"

if echo "$out" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1

// ==== sim/tb_gba_io_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the GBA I/O top level with seeded random bus, switch and
// game-pad stimulus, a pad model and a run watchdog
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_gba_io_top
    import gba_io_pkg::*;
();

    localparam int N_WORD   = 200;
    localparam int N_NARROW = 300;
    localparam int N_IGNORE = 150;
    localparam int N_PAD    = 5;
    localparam int N_LED    = 20;
    // Each pad word is budgeted four scans for three held plus alignment
    localparam int BUDGET = 10 + 256 + 2 * N_WORD + 2 * N_NARROW + 2 * N_IGNORE + 60
                          + N_PAD * 4 * PAD_TICKS * PAD_DIV + N_LED * 20 + 1000;

    logic        clock = 1'b0;
    logic        rst_n;
    logic [31:0] bus_addr;
    logic [31:0] bus_wdata;
    logic [1:0]  bus_size;
    logic        bus_write;
    logic [31:0] bus_rdata;
    logic [7:0]  SW;
    logic        JA1;
    logic        JA2;
    logic        JA3;
    logic [7:0]  LD;
    logic [15:0] pad_word;               // Active-high pressed buttons
    logic [15:0] pad_shift = 16'hffff;   // Active-low pad shift register
    logic        ja2_prev  = 1'b0;
    logic        ja3_prev  = 1'b0;
    int          checks;
    int          errors;
    int          test_num  = 0;
    int          chk_mark  = 0;
    int          err_mark  = 0;

    always #20 clock = ~clock;

    // Game-pad model loads on latch and shifts on the rising pad clock
    assign JA1 = pad_shift[0];
    always @(posedge clock) begin
        if (!rst_n) begin
            pad_shift <= 16'hffff;
        end else if (JA2 && !ja2_prev) begin
            pad_shift <= ~pad_word;
        end else if (JA3 && !ja3_prev) begin
            pad_shift <= {1'b1, pad_shift[15:1]};   // Released after the last button
        end
        ja2_prev <= JA2;
        ja3_prev <= JA3;
    end

    gba_io_top u_gba_io_top (
        .clock     (clock),
        .rst_n     (rst_n),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_size  (bus_size),
        .bus_write (bus_write),
        .bus_rdata (bus_rdata),
        .SW        (SW),
        .JA1       (JA1),
        .JA2       (JA2),
        .JA3       (JA3),
        .LD        (LD)
    );

    io_checker u_io_checker (
        .clock     (clock),
        .rst_n     (rst_n),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_size  (bus_size),
        .bus_write (bus_write),
        .bus_rdata (bus_rdata),
        .SW        (SW),
        .LD        (LD),
        .JA2       (JA2),
        .JA3       (JA3),
        .pad_word  (pad_word),
        .checks    (checks),
        .errors    (errors)
    );

    function automatic logic [31:0] reg_addr(input logic [2:0] idx, input logic [1:0] lane);
        return {IO_BASE[31:5], idx, lane};
    endfunction

    // Either fully random or just above the bank
    function automatic logic [31:0] outside_addr();
        logic [31:0] addr;
        addr = $urandom;
        if (addr[0]) begin
            addr = IO_BASE + 32'h20 + {26'h0, addr[6:1]};
        end
        if (addr[31:5] == IO_BASE[31:5]) begin
            addr[31] = ~addr[31];
        end
        return addr;
    endfunction

    task automatic write_bus(input logic [31:0] addr, input logic [1:0] size,
                             input logic [31:0] data);
        @(posedge clock);
        bus_addr  <= addr;
        bus_size  <= size;
        bus_wdata <= data;
        bus_write <= 1'b1;
    endtask

    task automatic read_bus(input logic [31:0] addr);
        @(posedge clock);
        bus_addr  <= addr;
        bus_size  <= 2'($urandom);
        bus_wdata <= $urandom;
        bus_write <= 1'b0;
    endtask

    task automatic close_test(input string name);
        repeat (3) begin
            @(posedge clock);
            bus_write <= 1'b0;
        end
        @(negedge clock);   // Checker counts from the last edge have landed
        test_num++;
        $display("Test %0d %s: %0d checks, %0d errors", test_num, name,
                 checks - chk_mark, errors - err_mark);
        chk_mark = checks;
        err_mark = errors;
    endtask

    initial begin : main
        logic [2:0] idx;
        int         rises;

        void'($urandom(32'h9d9d55ab));
        rst_n      = 1'b0;
        bus_addr   = 32'h0;
        bus_wdata  = 32'h0;
        bus_size   = SIZE_WORD;
        bus_write  = 1'b0;
        SW         = 8'h00;
        pad_word   = 16'h0000;
        repeat (10) begin
            @(posedge clock);
            SW <= 8'($urandom);
        end
        rst_n <= 1'b1;

        for (int s = 0; s < 256; s++) begin
            read_bus(reg_addr(3'($urandom), 2'd0));
            SW <= 8'(s);
        end
        close_test("reset values and blank LEDs");

        for (int n = 0; n < N_WORD; n++) begin
            idx = 3'($urandom);
            write_bus(reg_addr(idx, 2'd0), SIZE_WORD, $urandom);
            read_bus(reg_addr(idx, 2'($urandom)));
            SW <= 8'($urandom);
        end
        close_test("word write then read");

        for (int n = 0; n < N_NARROW; n++) begin
            idx = 3'($urandom);
            write_bus(reg_addr(idx, 2'($urandom)), 2'($urandom % 2), $urandom);
            read_bus(reg_addr(idx, 2'd0));
        end
        for (int i = 0; i < 8; i++) begin
            read_bus(reg_addr(3'(i), 2'd0));
        end
        close_test("byte and halfword merges");

        for (int n = 0; n < N_IGNORE; n++) begin
            case ($urandom % 3)
                0:       write_bus(reg_addr(3'(KEYINPUT_IDX), 2'($urandom)),
                                   2'($urandom), $urandom);
                1:       write_bus(outside_addr(), 2'($urandom), $urandom);
                default: read_bus(outside_addr());
            endcase
        end
        for (int i = 0; i < 8; i++) begin
            read_bus(reg_addr(3'(i), 2'd0));
        end
        close_test("ignored writes and outside reads");

        // Hold each pad word for three latch pulses
        for (int p = 0; p < N_PAD; p++) begin
            @(posedge clock);
            pad_word <= 16'($urandom);
            rises = 0;
            while (rises < 3) begin
                read_bus(reg_addr(3'(KEYINPUT_IDX), 2'd0));
                SW <= 8'($urandom);
                if (JA2 && !ja2_prev) begin
                    rises++;
                end
            end
        end
        close_test("game-pad buttons");

        for (int r = 0; r < N_LED; r++) begin
            for (int i = 0; i < 4; i++) begin
                write_bus(reg_addr(3'(i), 2'd0), SIZE_WORD, $urandom);
            end
            for (int s = 0; s < 16; s++) begin
                read_bus(reg_addr(3'($urandom), 2'd0));
                SW <= 8'(s);
            end
        end
        close_test("LED byte select");

        $display("Totals: %0d tests, %0d checks, %0d errors", test_num, checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (BUDGET) @(posedge clock);
        $display("Watchdog timeout: run did not finish within %0d cycles", BUDGET);
        $display("Simulation FAILED");
        $finish;
    end

endmodule : tb_gba_io_top

`default_nettype wire

// ==== sim/io_checker.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench checker: mirrors the I/O registers from bus traffic and
// compares read data, LEDs and reset values every cycle
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module io_checker
    import gba_io_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    input  logic [31:0] bus_addr,
    input  logic [31:0] bus_wdata,
    input  logic [1:0]  bus_size,
    input  logic        bus_write,
    input  logic [31:0] bus_rdata,
    input  logic [7:0]  SW,
    input  logic [7:0]  LD,
    input  logic        JA2,
    input  logic        JA3,
    input  logic [15:0] pad_word,
    output int          checks,
    output int          errors
);

    logic [31:0] mirror [NUM_IO_REGS];
    logic [31:0] rd_exp;
    logic        rd_pending = 1'b0;   // rd_exp holds a known value
    logic        reset_seen = 1'b0;
    logic [15:0] key_exp    = 16'h0000;
    logic        key_valid  = 1'b1;   // Buttons settled on key_exp
    logic [15:0] pad_prev   = 16'h0000;
    logic        latch_prev = 1'b0;
    int          latch_rises;

    function automatic int value_differs(input string name, input logic [31:0] exp,
                                         input logic [31:0] act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %0h, actual %0h", name, exp, act);
            return 1;
        end
        return 0;
    endfunction

    always @(posedge clock) begin : watch
        int          err_now;
        int          chk_now;
        io_word_t    ld_word;
        logic [7:0]  ld_exp;
        logic        ld_known;
        logic        in_bank;
        logic [2:0]  idx;
        logic [31:0] mask;
        logic [31:0] lanes;

        err_now = 0;
        chk_now = 0;
        in_bank = (bus_addr[31:5] == IO_BASE[31:5]);
        idx     = bus_addr[4:2];
        if (!rst_n) begin
            if (reset_seen) begin
                chk_now = 4;
                err_now += value_differs("bus_rdata", 32'h0, bus_rdata);
                err_now += value_differs("JA2", 32'h0, {31'h0, JA2});
                err_now += value_differs("JA3", 32'h0, {31'h0, JA3});
                err_now += value_differs("LD", 32'h0, {24'h0, LD});
            end
            for (int i = 0; i < NUM_IO_REGS; i++) begin
                mirror[i] = 32'h0;
            end
            rd_pending  = 1'b0;
            key_exp     = 16'h0000;
            key_valid   = 1'b1;
            pad_prev    = 16'h0000;
            latch_prev  = JA2;
            latch_rises = 0;
            reset_seen  = 1'b1;
        end else begin
            // New pad word settles by the second latch pulse
            if (pad_word != pad_prev) begin
                key_valid   = 1'b0;
                latch_rises = 0;
            end
            if (JA2 && !latch_prev && !key_valid) begin
                latch_rises++;
                if (latch_rises == 2) begin
                    key_valid = 1'b1;
                    key_exp   = pad_word;
                end
            end
            pad_prev   = pad_word;
            latch_prev = JA2;

            if (rd_pending) begin
                chk_now++;
                err_now += value_differs("bus_rdata", rd_exp, bus_rdata);
            end

            ld_known = 1'b1;
            if (SW < 8'h10) begin
                ld_word = mirror[{1'b0, SW[3:2]}];
                ld_exp  = ld_word.bytes[SW[1:0]];
            end else begin
                ld_exp   = SW[7] ? key_exp[15:8] : key_exp[7:0];
                ld_known = key_valid;
            end
            if (ld_known) begin
                chk_now++;
                err_now += value_differs("LD", {24'h0, ld_exp}, {24'h0, LD});
            end

            // Expected data for the address seen at this edge
            rd_pending = 1'b1;
            if (!in_bank) begin
                rd_exp = 32'h0;
            end else if (idx == 3'(KEYINPUT_IDX)) begin
                rd_exp     = {16'h0000, key_exp};
                rd_pending = key_valid;
            end else begin
                rd_exp = mirror[idx];
            end

            if (bus_write && in_bank && idx != 3'(KEYINPUT_IDX)) begin
                case (bus_size)
                    SIZE_BYTE: begin
                        mask  = 32'hff << (8 * bus_addr[1:0]);
                        lanes = {4{bus_wdata[7:0]}};
                    end
                    SIZE_HALF: begin
                        mask  = 32'hffff << (16 * bus_addr[1]);
                        lanes = {2{bus_wdata[15:0]}};
                    end
                    default: begin
                        mask  = 32'hffff_ffff;
                        lanes = bus_wdata;
                    end
                endcase
                mirror[idx] = (mirror[idx] & ~mask) | (lanes & mask);
            end
        end
        checks <= checks + chk_now;
        errors <= errors + err_now;
    end

endmodule : io_checker

`default_nettype wire

// ==== rtl/gba_io_top.sv ====
////////////////////////////////////////////////////////////////////////////
// GBA I/O top level: register bank, game-pad scanner and LED debug mux
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module gba_io_top (
    input  logic        clock,
    input  logic        rst_n,
    input  logic [31:0] bus_addr,
    input  logic [31:0] bus_wdata,
    input  logic [1:0]  bus_size,
    input  logic        bus_write,
    output logic [31:0] bus_rdata,
    input  logic [7:0]  SW,
    input  logic        JA1,    // Pad serial data
    output logic        JA2,    // Pad latch
    output logic        JA3,    // Pad clock
    output logic [7:0]  LD
);

    logic [15:0] buttons;
    logic [31:0] led_reg0, led_reg1, led_reg2, led_reg3;

    io_regs u_io_regs (
        .clock, .rst_n,
        .bus_addr, .bus_wdata, .bus_size, .bus_write, .bus_rdata,
        .buttons,
        .led_reg0, .led_reg1, .led_reg2, .led_reg3
    );

    // Pad on header JA
    snes_controller u_snes_controller (
        .clock, .rst_n,
        .serial_data (JA1),
        .data_latch  (JA2),
        .data_clock  (JA3),
        .buttons
    );

    led_controller u_led_controller (
        .SW,
        .led_reg0, .led_reg1, .led_reg2, .led_reg3,
        .buttons,
        .LD
    );

endmodule : gba_io_top

`default_nettype wire

// ==== rtl/led_controller.sv ====
////////////////////////////////////////////////////////////////////////////
// LED debug mux: switches pick a byte of a debug register or a half
// of the button word
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module led_controller
    import gba_io_pkg::*;
(
    input  logic [7:0]  SW,
    input  logic [31:0] led_reg0,
    input  logic [31:0] led_reg1,
    input  logic [31:0] led_reg2,
    input  logic [31:0] led_reg3,
    input  logic [15:0] buttons,
    output logic [7:0]  LD
);

    io_word_t sel_word;

    always_comb begin
        // SW[3:2] picks the debug register
        case (SW[3:2])
            2'd0:    sel_word = led_reg0;
            2'd1:    sel_word = led_reg1;
            2'd2:    sel_word = led_reg2;
            default: sel_word = led_reg3;
        endcase

        if (SW[7:4] == 4'h0) begin
            LD = sel_word.bytes[SW[1:0]];                  // Byte lane from SW[1:0]
        end else begin
            LD = SW[7] ? buttons[15:8] : buttons[7:0];     // Button halves
        end
    end

endmodule : led_controller

`default_nettype wire

// ==== rtl/snes_controller.sv ====
////////////////////////////////////////////////////////////////////////////
// Serial game-pad scanner: drives latch and clock, collects 16 buttons
// and publishes the active-high button word once per complete scan
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module snes_controller
    import gba_io_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    input  logic        serial_data,
    output logic        data_latch,
    output logic        data_clock,
    output logic [15:0] buttons
);

    logic [PAD_DIV_W-1:0]  div_cnt;
    logic [PAD_TICK_W-1:0] tick_cnt;
    logic [PAD_BITS-1:0]   shift_reg;
    logic                  tick_start;
    logic                  tick_end;
    logic                  last_tick;
    logic                  sample;

    assign tick_start = (div_cnt == '0);
    assign tick_end   = (div_cnt == PAD_DIV_W'(PAD_DIV - 1));
    assign last_tick  = (tick_cnt == PAD_TICK_W'(PAD_TICKS - 1));

    // Tick divider and position within the scan
    // Reset parks the scan in its idle tick so both pins start low
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            div_cnt  <= '0;
            tick_cnt <= PAD_TICK_W'(PAD_TICKS - 1);
        end else begin
            div_cnt <= tick_end ? '0 : div_cnt + 1'b1;
            if (tick_end) begin
                tick_cnt <= last_tick ? '0 : tick_cnt + 1'b1;
            end
        end
    end

    // Pin waveforms decoded from the tick count
    assign data_latch = (tick_cnt == '0);
    assign data_clock = (tick_cnt != '0) && !tick_cnt[0] &&
                        (tick_cnt <= PAD_TICK_W'(2 * PAD_BITS));

    // Sample at the start of each low half, before the pad shifts
    assign sample = tick_start && tick_cnt[0] &&
                    (tick_cnt < PAD_TICK_W'(2 * PAD_BITS));

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            shift_reg <= '1;     // Reads as all released until a real scan
        end else if (sample) begin
            shift_reg <= {serial_data, shift_reg[PAD_BITS-1:1]};
        end
    end

    // Publish only whole scans, pad data is active low
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            buttons <= '0;
        end else if (tick_end && last_tick) begin
            buttons <= ~shift_reg;
        end
    end

endmodule : snes_controller

`default_nettype wire

// ==== rtl/io_regs.sv ====
////////////////////////////////////////////////////////////////////////////
// Memory-mapped I/O register bank with byte, half and word writes,
// registered reads and the read-only key input register
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module io_regs
    import gba_io_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    input  logic [31:0] bus_addr,
    input  logic [31:0] bus_wdata,
    input  logic [1:0]  bus_size,
    input  logic        bus_write,
    output logic [31:0] bus_rdata,
    input  logic [15:0] buttons,
    output logic [31:0] led_reg0,
    output logic [31:0] led_reg1,
    output logic [31:0] led_reg2,
    output logic [31:0] led_reg3
);

    io_word_t   regs [NUM_IO_REGS];
    io_word_t   wr_word;
    io_word_t   merged;      // Selected register after the write lanes land
    logic [2:0] reg_idx;
    logic       in_bank;
    logic       is_keyinput;

    assign in_bank     = (bus_addr[31:5] == IO_BASE[31:5]);
    assign reg_idx     = bus_addr[4:2];
    assign is_keyinput = (reg_idx == KEYINPUT_IDX);
    assign wr_word     = bus_wdata;

    // Lane merge, narrow data always comes from the low end of wdata
    always_comb begin
        merged = regs[reg_idx];
        case (bus_size)
            SIZE_BYTE: merged.bytes[bus_addr[1:0]] = wr_word.bytes[0];
            SIZE_HALF: merged.halves[bus_addr[1]]  = wr_word.halves[0];
            default:   merged = wr_word;     // Word and code 3
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_IO_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (bus_write && in_bank && !is_keyinput) begin
            regs[reg_idx] <= merged;
        end
    end

    // Read data follows the address by one cycle
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            bus_rdata <= '0;
        end else if (!in_bank) begin
            bus_rdata <= '0;
        end else if (is_keyinput) begin
            bus_rdata <= {16'h0000, buttons};  // Live pad word, high half zero
        end else begin
            bus_rdata <= regs[reg_idx];
        end
    end

    // Debug words for the LED mux
    assign led_reg0 = regs[LED_REG0_IDX];
    assign led_reg1 = regs[LED_REG1_IDX];
    assign led_reg2 = regs[LED_REG2_IDX];
    assign led_reg3 = regs[LED_REG3_IDX];

endmodule : io_regs

`default_nettype wire

// ==== rtl/gba_io_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// GBA I/O subsystem definitions: address map, register indices, bus size
// codes, game-pad timing and the shared register word type
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package gba_io_pkg;

    // Register bank layout
    localparam int unsigned NUM_IO_REGS = 8;
    localparam logic [31:0] IO_BASE     = 32'h0400_0000;  // Bits 31:5 select the bank

    // Debug registers shown on the LEDs
    localparam int unsigned LED_REG0_IDX = 0;
    localparam int unsigned LED_REG1_IDX = 1;
    localparam int unsigned LED_REG2_IDX = 2;
    localparam int unsigned LED_REG3_IDX = 3;

    // Read-only button word, low half only
    localparam int unsigned KEYINPUT_IDX = 4;

    // bus_size encodings, code 3 behaves as a word
    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    // Game-pad scan timing
    localparam int unsigned PAD_DIV    = 8;                 // Clocks per tick
    localparam int unsigned PAD_BITS   = 16;                // Buttons per scan
    localparam int unsigned PAD_TICKS  = 2 * PAD_BITS + 2;  // Latch, 32 half clocks, idle
    localparam int unsigned PAD_DIV_W  = $clog2(PAD_DIV);
    localparam int unsigned PAD_TICK_W = $clog2(PAD_TICKS);

    // One register word, seen as byte lanes or as halfwords
    // Lane 0 and half 0 are the least significant
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } io_word_t;

endpackage : gba_io_pkg

`default_nettype wire
